// File: logic/a2card_cfg.svh
`ifndef A2CARD_CFG_SVH
`define A2CARD_CFG_SVH

// Apple II bus and screen geometry
`define A2_DATA_W 8
`define A2_LINE_W 10

// Audio sample and source widths
`define AUDIO_W 16
`define MB_AUDIO_W 10
`define MB_AUDIO_SHIFT 5
`define SPK_AUDIO_SHIFT 13

// One channel of an RGB pixel
`define COLOR_W 8

// Reset release counter and timing input synchronizer
`define RESET_CNT_W 4
`define SYNC_STAGES 2

// Feature enables
`define IRQ_OUT_ENABLE 1
`define BUS_DATA_OUT_ENABLE 1
`define SCANLINES_ENABLE 0
`define APPLE_SPEAKER_ENABLE 0

`endif

// File: logic/a2card_pkg.sv
`default_nettype none

`include "a2card_cfg.svh"

package a2card_pkg;

    // Bus response of a single card responder
    typedef struct packed {
        logic                   rd_en;
        logic [`A2_DATA_W-1:0]  data;
        logic                   irq_n;
    } card_resp_t;

    // Denoised timing input with its edge strobes
    typedef struct packed {
        logic level;
        logic rise;
        logic fall;
        logic any_edge;
    } timing_edge_t;

    typedef struct packed {
        logic [`COLOR_W-1:0] red;
        logic [`COLOR_W-1:0] green;
        logic [`COLOR_W-1:0] blue;
    } pixel_t;

    // Audio from SuperSprite, Mockingboard and the Apple speaker
    typedef struct packed {
        logic [`AUDIO_W-1:0]    ssp;
        logic [`MB_AUDIO_W-1:0] mb_l;
        logic [`MB_AUDIO_W-1:0] mb_r;
        logic                   speaker;
    } card_audio_t;

endpackage

`default_nettype wire

// File: logic/reset_sync.sv
`default_nettype none
`timescale 1ns/1ps

`include "a2card_cfg.svh"

module reset_sync (
    input  logic clk,
    input  logic ext_reset,
    output logic device_reset_n_o
);

    logic [`RESET_CNT_W-1:0] reset_cnt;

    // Counts up after release and holds at all ones
    always_ff @(posedge clk or negedge ext_reset) begin
        if (!ext_reset) begin
            reset_cnt <= '0;
        end else if (!device_reset_n_o) begin
            reset_cnt <= reset_cnt + 1'b1;
        end
    end

    // Design comes out of reset once the counter saturates
    assign device_reset_n_o = &reset_cnt;

endmodule

`default_nettype wire

// File: logic/bus_edge_sync.sv
`default_nettype none
`timescale 1ns/1ps

`include "a2card_cfg.svh"

module bus_edge_sync import a2card_pkg::*; (
    input  logic         clk,
    input  logic         device_reset_n_i,
    input  logic         async_i,
    output timing_edge_t sync_o
);

    logic [`SYNC_STAGES-1:0] sync_q;
    logic                    hist_q;
    logic                    synced;
    logic                    changing;
    timing_edge_t            edge_q;

    assign synced = sync_q[`SYNC_STAGES-1];

    // A new level is taken only after two matching synchronized samples,
    // so a single-sample glitch never reaches the output
    always_comb begin
        changing = (synced == hist_q) && (synced != edge_q.level);
    end

    always_ff @(posedge clk or negedge device_reset_n_i) begin
        if (!device_reset_n_i) begin
            sync_q <= '0;
            hist_q <= 1'b0;
            edge_q <= '0;
        end else begin
            sync_q <= {sync_q[`SYNC_STAGES-2:0], async_i};
            hist_q <= synced;

            if (changing) begin
                edge_q.level <= synced;
            end

            // Strobes last one cycle, in the cycle the level moves
            edge_q.rise     <= changing && synced;
            edge_q.fall     <= changing && !synced;
            edge_q.any_edge <= changing;
        end
    end

    assign sync_o = edge_q;

endmodule

`default_nettype wire

// File: logic/card_bus_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

`include "a2card_cfg.svh"

module card_bus_arbiter import a2card_pkg::*; (
    input  logic                  clk,
    input  logic                  device_reset_n_i,
    input  card_resp_t            ssc_i,
    input  card_resp_t            ssp_i,
    input  card_resp_t            mb_i,
    input  logic [`A2_DATA_W-1:0] a2_d_i,
    output logic [`A2_DATA_W-1:0] a2_d_o,
    output logic                  a2_d_dir_o,
    output logic                  a2_irq_n_o
);

    logic [`A2_DATA_W-1:0] sel_data;
    logic                  any_rd;
    logic                  irq_n_all;

    // SuperSerial wins over SuperSprite, which wins over Mockingboard
    always_comb begin
        if (ssc_i.rd_en) begin
            sel_data = ssc_i.data;
        end else if (ssp_i.rd_en) begin
            sel_data = ssp_i.data;
        end else if (mb_i.rd_en) begin
            sel_data = mb_i.data;
        end else begin
            // Nobody reads, so the latched bus byte goes back out
            sel_data = a2_d_i;
        end
    end

    assign any_rd    = ssc_i.rd_en | ssp_i.rd_en | mb_i.rd_en;
    assign irq_n_all = ssc_i.irq_n & ssp_i.irq_n & mb_i.irq_n;

    // Direction 1 means the card drives the Apple II data bus
    always_ff @(posedge clk or negedge device_reset_n_i) begin
        if (!device_reset_n_i) begin
            a2_d_dir_o <= 1'b0;
            a2_irq_n_o <= 1'b1;
        end else begin
            a2_d_dir_o <= any_rd && (`BUS_DATA_OUT_ENABLE != 0);
            a2_irq_n_o <= irq_n_all || (`IRQ_OUT_ENABLE == 0);
        end
    end

    always_ff @(posedge clk) begin
        a2_d_o <= sel_data;
    end

endmodule

`default_nettype wire

// File: logic/audio_mixer.sv
`default_nettype none
`timescale 1ns/1ps

`include "a2card_cfg.svh"

module audio_mixer import a2card_pkg::*; (
    input  logic                clk,
    input  logic                device_reset_n_i,
    input  card_audio_t         audio_i,
    input  logic                speaker_sw_i,
    output logic [`AUDIO_W-1:0] audio_l_o,
    output logic [`AUDIO_W-1:0] audio_r_o
);

    logic speaker_bit;

    // Sum of one channel, wrapping at the sample width
    function automatic logic [`AUDIO_W-1:0] mix_channel(
        input logic [`AUDIO_W-1:0]    ssp,
        input logic [`MB_AUDIO_W-1:0] mb,
        input logic                   spk
    );
        logic [`AUDIO_W-1:0] mb_term;
        logic [`AUDIO_W-1:0] spk_term;
        mb_term  = `AUDIO_W'(mb) << `MB_AUDIO_SHIFT;
        spk_term = `AUDIO_W'(spk) << `SPK_AUDIO_SHIFT;
        return ssp + mb_term + spk_term;
    endfunction

    // Speaker is heard when forced on or when dip 1 is pressed
    assign speaker_bit = audio_i.speaker & ((`APPLE_SPEAKER_ENABLE != 0) | speaker_sw_i);

    always_ff @(posedge clk or negedge device_reset_n_i) begin
        if (!device_reset_n_i) begin
            audio_l_o <= '0;
            audio_r_o <= '0;
        end else begin
            audio_l_o <= mix_channel(audio_i.ssp, audio_i.mb_l, speaker_bit);
            audio_r_o <= mix_channel(audio_i.ssp, audio_i.mb_r, speaker_bit);
        end
    end

endmodule

`default_nettype wire

// File: logic/scanline_dimmer.sv
`default_nettype none
`timescale 1ns/1ps

`include "a2card_cfg.svh"

module scanline_dimmer import a2card_pkg::*; (
    input  logic                  clk,
    input  logic                  device_reset_n_i,
    input  pixel_t                pixel_i,
    input  logic [`A2_LINE_W-1:0] line_i,
    input  logic                  scanline_sw_i,
    output pixel_t                pixel_o
);

    logic dim;

    function automatic logic [`COLOR_W-1:0] dim_color(
        input logic [`COLOR_W-1:0] color,
        input logic                en
    );
        return en ? (color >> 1) : color;
    endfunction

    // Only odd lines get darkened
    assign dim = ((`SCANLINES_ENABLE != 0) | scanline_sw_i) & line_i[0];

    always_ff @(posedge clk or negedge device_reset_n_i) begin
        if (!device_reset_n_i) begin
            pixel_o <= '0;
        end else begin
            pixel_o.red   <= dim_color(pixel_i.red, dim);
            pixel_o.green <= dim_color(pixel_i.green, dim);
            pixel_o.blue  <= dim_color(pixel_i.blue, dim);
        end
    end

endmodule

`default_nettype wire

// File: logic/a2card_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "a2card_cfg.svh"

module a2card_top import a2card_pkg::*; (
    input  logic                  clk,
    input  logic                  ext_reset,

    // Apple II timing inputs
    input  logic                  a2_phi1_i,
    input  logic                  a2_q3_i,
    input  logic                  a2_7m_i,

    // Data bus and card responders
    input  logic [`A2_DATA_W-1:0] a2_d_i,
    input  card_resp_t            ssc_i,
    input  card_resp_t            ssp_i,
    input  card_resp_t            mb_i,

    // Card audio and video
    input  card_audio_t           audio_i,
    input  pixel_t                pixel_i,
    input  logic [`A2_LINE_W-1:0] line_i,
    input  logic [3:0]            dip_switches_n_i,

    output logic                  device_reset_n_o,
    output logic                  phi0_o,
    output timing_edge_t          phi1_o,
    output timing_edge_t          q3_o,
    output timing_edge_t          m7_o,
    output logic [`A2_DATA_W-1:0] a2_d_o,
    output logic                  a2_d_dir_o,
    output logic                  a2_irq_n_o,
    output logic [`AUDIO_W-1:0]   audio_l_o,
    output logic [`AUDIO_W-1:0]   audio_r_o,
    output pixel_t                pixel_o
);

    logic       device_reset_n;
    logic [1:0] dip_sw;

    reset_sync reset_sync_i (
        .clk              (clk),
        .ext_reset        (ext_reset),
        .device_reset_n_o (device_reset_n)
    );

    assign device_reset_n_o = device_reset_n;

    // Timing inputs into the clk domain
    bus_edge_sync phi1_sync_i (
        .clk              (clk),
        .device_reset_n_i (device_reset_n),
        .async_i          (a2_phi1_i),
        .sync_o           (phi1_o)
    );

    bus_edge_sync q3_sync_i (
        .clk              (clk),
        .device_reset_n_i (device_reset_n),
        .async_i          (a2_q3_i),
        .sync_o           (q3_o)
    );

    // 14M strobe is the any_edge of this one
    bus_edge_sync m7_sync_i (
        .clk              (clk),
        .device_reset_n_i (device_reset_n),
        .async_i          (a2_7m_i),
        .sync_o           (m7_o)
    );

    assign phi0_o = ~phi1_o.level;

    // Switches read 0 when pressed
    assign dip_sw = ~dip_switches_n_i[1:0];

    card_bus_arbiter card_bus_arbiter_i (
        .clk              (clk),
        .device_reset_n_i (device_reset_n),
        .ssc_i            (ssc_i),
        .ssp_i            (ssp_i),
        .mb_i             (mb_i),
        .a2_d_i           (a2_d_i),
        .a2_d_o           (a2_d_o),
        .a2_d_dir_o       (a2_d_dir_o),
        .a2_irq_n_o       (a2_irq_n_o)
    );

    audio_mixer audio_mixer_i (
        .clk              (clk),
        .device_reset_n_i (device_reset_n),
        .audio_i          (audio_i),
        .speaker_sw_i     (dip_sw[1]),
        .audio_l_o        (audio_l_o),
        .audio_r_o        (audio_r_o)
    );

    scanline_dimmer scanline_dimmer_i (
        .clk              (clk),
        .device_reset_n_i (device_reset_n),
        .pixel_i          (pixel_i),
        .line_i           (line_i),
        .scanline_sw_i    (dip_sw[0]),
        .pixel_o          (pixel_o)
    );

endmodule

`default_nettype wire

// File: bench/a2card_sva.sv
`default_nettype none
`timescale 1ns/1ps

module a2card_sva import a2card_pkg::*; (
    input logic         clk,
    input logic         device_reset_n_i,
    input logic         phi0_i,
    input timing_edge_t phi1_i,
    input timing_edge_t q3_i,
    input timing_edge_t m7_i,
    input logic         a2_d_dir_i
);

    // A timing input cannot rise and fall in the same cycle
    property edge_exclusive(timing_edge_t e);
        @(posedge clk) disable iff (!device_reset_n_i) !(e.rise && e.fall);
    endproperty

    // The combined strobe tracks the two edge strobes
    property edge_combined(timing_edge_t e);
        @(posedge clk) disable iff (!device_reset_n_i) e.any_edge == (e.rise || e.fall);
    endproperty

    phi1_excl_a: assert property (edge_exclusive(phi1_i))
        else $error("phi1 rise and fall high together");
    q3_excl_a: assert property (edge_exclusive(q3_i))
        else $error("q3 rise and fall high together");
    m7_excl_a: assert property (edge_exclusive(m7_i))
        else $error("7M rise and fall high together");

    phi1_any_a: assert property (edge_combined(phi1_i))
        else $error("phi1 any_edge differs from rise or fall");
    q3_any_a: assert property (edge_combined(q3_i))
        else $error("q3 any_edge differs from rise or fall");
    m7_any_a: assert property (edge_combined(m7_i))
        else $error("7M any_edge differs from rise or fall");

    // Card must not drive the bus while held in reset
    dir_reset_a: assert property (@(posedge clk) !device_reset_n_i |-> !a2_d_dir_i)
        else $error("bus direction set during reset");

    phi0_a: assert property (@(posedge clk) phi0_i == !phi1_i.level)
        else $error("phi0 is not the inverse of the phi1 level");

endmodule

bind a2card_top a2card_sva sva_i (
    .clk              (clk),
    .device_reset_n_i (device_reset_n_o),
    .phi0_i           (phi0_o),
    .phi1_i           (phi1_o),
    .q3_i             (q3_o),
    .m7_i             (m7_o),
    .a2_d_dir_i       (a2_d_dir_o)
);

`default_nettype wire

// File: bench/a2card_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "a2card_cfg.svh"

module a2card_tb import a2card_pkg::*;;

    // One stimulus row with its expected outputs
    typedef struct packed {
        card_resp_t            ssc;
        card_resp_t            ssp;
        card_resp_t            mb;
        logic [`A2_DATA_W-1:0] bus;
        card_audio_t           audio;
        pixel_t                pix;
        logic [`A2_LINE_W-1:0] line;
        logic [3:0]            dip_n;
        logic [`A2_DATA_W-1:0] exp_d;
        logic                  exp_dir;
        logic                  exp_irq_n;
        logic [`AUDIO_W-1:0]   exp_l;
        logic [`AUDIO_W-1:0]   exp_r;
        pixel_t                exp_pix;
    } vec_t;

    logic                  clk;
    logic                  ext_reset;
    logic                  a2_phi1;
    logic                  a2_q3;
    logic                  a2_7m;
    logic [`A2_DATA_W-1:0] a2_d;
    card_resp_t            ssc;
    card_resp_t            ssp;
    card_resp_t            mb;
    card_audio_t           audio;
    pixel_t                pixel;
    logic [`A2_LINE_W-1:0] line;
    logic [3:0]            dip_switches_n;

    logic                  device_reset_n_o;
    logic                  phi0_o;
    timing_edge_t          phi1_o;
    timing_edge_t          q3_o;
    timing_edge_t          m7_o;
    logic [`A2_DATA_W-1:0] a2_d_o;
    logic                  a2_d_dir_o;
    logic                  a2_irq_n_o;
    logic [`AUDIO_W-1:0]   audio_l_o;
    logic [`AUDIO_W-1:0]   audio_r_o;
    pixel_t                pixel_o;

    vec_t table_q[$];
    int   error_count = 0;

    a2card_top dut_i (
        .clk (clk), .ext_reset (ext_reset),
        .a2_phi1_i (a2_phi1), .a2_q3_i (a2_q3), .a2_7m_i (a2_7m),
        .a2_d_i (a2_d), .ssc_i (ssc), .ssp_i (ssp), .mb_i (mb),
        .audio_i (audio), .pixel_i (pixel), .line_i (line),
        .dip_switches_n_i (dip_switches_n),
        .device_reset_n_o (device_reset_n_o), .phi0_o (phi0_o),
        .phi1_o (phi1_o), .q3_o (q3_o), .m7_o (m7_o),
        .a2_d_o (a2_d_o), .a2_d_dir_o (a2_d_dir_o), .a2_irq_n_o (a2_irq_n_o),
        .audio_l_o (audio_l_o), .audio_r_o (audio_r_o), .pixel_o (pixel_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic card_resp_t build_resp(input logic rd, input logic [7:0] d,
                                              input logic irq_n);
        card_resp_t r;
        r.rd_en = rd;
        r.data  = d;
        r.irq_n = irq_n;
        return r;
    endfunction

    function automatic card_audio_t pack_audio(input logic [15:0] s, input logic [9:0] l,
                                               input logic [9:0] r, input logic spk);
        card_audio_t a;
        a.ssp     = s;
        a.mb_l    = l;
        a.mb_r    = r;
        a.speaker = spk;
        return a;
    endfunction

    task automatic add_row(input card_resp_t c0, input card_resp_t c1, input card_resp_t c2,
                           input logic [7:0] b, input card_audio_t a, input pixel_t p,
                           input logic [9:0] ln, input logic [3:0] dn,
                           input logic [7:0] ed, input logic edir, input logic eirq,
                           input logic [15:0] el, input logic [15:0] er, input pixel_t ep);
        vec_t v;
        v = {c0, c1, c2, b, a, p, ln, dn, ed, edir, eirq, el, er, ep};
        table_q.push_back(v);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Done: errors found");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("Done: errors found");
        $fatal(1, "stopping on timeout");
    endtask

    initial begin
        vec_t row;
        int   cycles;
        int   rise_cnt;
        int   fall_cnt;
        int   edge_cnt;

        ext_reset = 1'b0;
        a2_phi1 = 1'b0;
        a2_q3 = 1'b0;
        a2_7m = 1'b0;
        a2_d = '0;
        ssc = build_resp(1'b0, 8'h00, 1'b1);
        ssp = build_resp(1'b0, 8'h00, 1'b1);
        mb = build_resp(1'b0, 8'h00, 1'b1);
        audio = '0;
        pixel = '0;
        line = '0;
        dip_switches_n = 4'hF;

        // Bus priority, interrupts, audio sums with wrap, dimming on odd lines
        add_row(build_resp(0, 8'h11, 1), build_resp(0, 8'h22, 1), build_resp(0, 8'h33, 1),
                8'h3C, pack_audio(16'h1000, 10'h001, 10'h002, 0), 24'h804020, 10'd0, 4'hF,
                8'h3C, 1'b0, 1'b1, 16'h1020, 16'h1040, 24'h804020);
        add_row(build_resp(1, 8'hA5, 1), build_resp(1, 8'h5A, 1), build_resp(1, 8'h77, 1),
                8'h3C, pack_audio(16'h0000, 10'h3FF, 10'h000, 1), 24'h804020, 10'd1, 4'hF,
                8'hA5, 1'b1, 1'b1, 16'h7FE0, 16'h0000, 24'h804020);
        add_row(build_resp(0, 8'hA5, 1), build_resp(1, 8'h5A, 0), build_resp(1, 8'h77, 1),
                8'h3C, pack_audio(16'h0100, 10'h010, 10'h000, 1), 24'hFF8102, 10'd3, 4'hD,
                8'h5A, 1'b1, 1'b0, 16'h2300, 16'h2100, 24'hFF8102);
        add_row(build_resp(0, 8'hA5, 1), build_resp(0, 8'h5A, 1), build_resp(1, 8'h77, 0),
                8'h3C, pack_audio(16'hFFFF, 10'h3FF, 10'h001, 1), 24'hFF8102, 10'd5, 4'hC,
                8'h77, 1'b1, 1'b0, 16'h9FDF, 16'h201F, 24'h7F4001);
        add_row(build_resp(0, 8'hA5, 0), build_resp(0, 8'h5A, 1), build_resp(0, 8'h77, 1),
                8'hC3, pack_audio(16'hE000, 10'h3FF, 10'h100, 1), 24'h123456, 10'd2, 4'hE,
                8'hC3, 1'b0, 1'b0, 16'h5FE0, 16'h0000, 24'h123456);
        add_row(build_resp(1, 8'h00, 1), build_resp(1, 8'h5A, 1), build_resp(1, 8'h77, 1),
                8'hFF, pack_audio(16'h0001, 10'h000, 10'h000, 1), 24'h123456, 10'd7, 4'hE,
                8'h00, 1'b1, 1'b1, 16'h0001, 16'h0001, 24'h091A2B);
        add_row(build_resp(0, 8'hA5, 0), build_resp(1, 8'h96, 1), build_resp(0, 8'h77, 0),
                8'h3C, pack_audio(16'h8000, 10'h200, 10'h3FF, 1), 24'h01FE80, 10'h3FF, 4'h5,
                8'h96, 1'b1, 1'b0, 16'hE000, 16'h1FE0, 24'h01FE80);
        add_row(build_resp(0, 8'hA5, 1), build_resp(0, 8'h96, 1), build_resp(0, 8'h77, 1),
                8'h5A, pack_audio(16'h0000, 10'h000, 10'h000, 1), 24'h01FE80, 10'h3FF, 4'h6,
                8'h5A, 1'b0, 1'b1, 16'h0000, 16'h0000, 24'h007F40);

        // Hold reset, then wait for the internal release
        repeat (3) @(negedge clk);
        ext_reset = 1'b1;
        cycles = 0;
        while (device_reset_n_o !== 1'b1) begin
            check_value("a2_d_dir_o", a2_d_dir_o, 1'b0);
            check_value("a2_irq_n_o", a2_irq_n_o, 1'b1);
            if (cycles == 20) begin
                report_timeout("device_reset_n_o after ext_reset release");
            end
            @(posedge clk);
            #1;
            cycles++;
        end

        for (int i = 0; i < table_q.size(); i++) begin
            row = table_q[i];
            @(negedge clk);
            ssc = row.ssc;
            ssp = row.ssp;
            mb = row.mb;
            a2_d = row.bus;
            audio = row.audio;
            pixel = row.pix;
            line = row.line;
            dip_switches_n = row.dip_n;
            @(posedge clk);
            #1;
            check_value("a2_d_o", a2_d_o, row.exp_d);
            check_value("a2_d_dir_o", a2_d_dir_o, row.exp_dir);
            check_value("a2_irq_n_o", a2_irq_n_o, row.exp_irq_n);
            check_value("audio_l_o", audio_l_o, row.exp_l);
            check_value("audio_r_o", audio_r_o, row.exp_r);
            check_value("pixel_o", pixel_o, row.exp_pix);
        end

        // Clean step on phi1
        @(negedge clk);
        a2_phi1 = 1'b1;
        cycles = 0;
        rise_cnt = 0;
        fall_cnt = 0;
        while (phi1_o.level !== 1'b1) begin
            if (cycles == 10) begin
                report_timeout("phi1_o.level to follow a2_phi1_i");
            end
            @(posedge clk);
            #1;
            cycles++;
            rise_cnt += phi1_o.rise;
            fall_cnt += phi1_o.fall;
            check_value("phi0_o", phi0_o, !phi1_o.level);
        end
        repeat (4) begin
            @(posedge clk);
            #1;
            rise_cnt += phi1_o.rise;
            fall_cnt += phi1_o.fall;
        end
        check_value("phi1_o.rise count", rise_cnt, 1);
        check_value("phi1_o.fall count", fall_cnt, 0);
        check_value("phi0_o", phi0_o, 1'b0);

        // Clean high pulse on q3, one rise and one fall expected
        @(negedge clk);
        a2_q3 = 1'b1;
        cycles = 0;
        rise_cnt = 0;
        fall_cnt = 0;
        while (q3_o.level !== 1'b1) begin
            if (cycles == 10) begin
                report_timeout("q3_o.level to rise after a2_q3_i");
            end
            @(posedge clk);
            #1;
            cycles++;
            rise_cnt += q3_o.rise;
            fall_cnt += q3_o.fall;
        end
        @(negedge clk);
        a2_q3 = 1'b0;
        cycles = 0;
        while (q3_o.level !== 1'b0) begin
            if (cycles == 10) begin
                report_timeout("q3_o.level to fall after a2_q3_i");
            end
            @(posedge clk);
            #1;
            cycles++;
            rise_cnt += q3_o.rise;
            fall_cnt += q3_o.fall;
        end
        repeat (4) begin
            @(posedge clk);
            #1;
            rise_cnt += q3_o.rise;
            fall_cnt += q3_o.fall;
        end
        check_value("q3_o.rise count", rise_cnt, 1);
        check_value("q3_o.fall count", fall_cnt, 1);

        // 7M toggling slow enough to pass the glitch filter
        edge_cnt = 0;
        for (int t = 0; t < 6; t++) begin
            @(negedge clk);
            a2_7m = ~a2_7m;
            repeat (4) begin
                @(posedge clk);
                #1;
                edge_cnt += m7_o.any_edge;
            end
        end
        cycles = 0;
        while (m7_o.level !== a2_7m) begin
            if (cycles == 10) begin
                report_timeout("m7_o.level to settle");
            end
            @(posedge clk);
            #1;
            cycles++;
            edge_cnt += m7_o.any_edge;
        end
        check_value("m7_o.any_edge count", edge_cnt, 6);

        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: a2card_glue.f
+incdir+logic
logic/a2card_pkg.sv
logic/reset_sync.sv
logic/bus_edge_sync.sv
logic/card_bus_arbiter.sv
logic/audio_mixer.sv
logic/scanline_dimmer.sv
logic/a2card_top.sv
bench/a2card_sva.sv
bench/a2card_tb.sv
